// File: Makefile
BIN := obj_dir/Vtb_data_cache
SRC := $(wildcard source/*.sv sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): filelist.f $(SRC)
	verilator --binary --timing --assert -j 0 --top-module tb_data_cache -f filelist.f

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir

// File: filelist.f
source/cache_cfg_pkg.sv
source/cache_ctrl_pkg.sv
source/array_port_if.sv
source/lookup_if.sv
source/way_array.sv
source/tag_compare.sv
source/cache_controller.sv
source/data_cache.sv
sim/main_memory_model.sv
sim/tb_data_cache.sv

// File: sim/main_memory_model.sv
`timescale 1ns/1ns

module main_memory_model (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  mem_req,
    input  logic                  mem_write,
    input  cache_cfg_pkg::block_t mem_addr,
    input  cache_cfg_pkg::line_t  mem_wdata,
    output logic                  mem_ack,
    output cache_cfg_pkg::line_t  mem_rdata,
    output int                    req_count,
    output int                    wb_count,
    output cache_cfg_pkg::block_t last_wb_addr,
    output cache_cfg_pkg::line_t  last_wb_data
);

    localparam int WB = cache_cfg_pkg::WORD_BITS;

    cache_cfg_pkg::word_t mem [65536];
    int                   delay;
    logic                 pending;

    // one process owns every output, changes land on the falling edge
    initial begin
        mem_ack      = 1'b0;
        mem_rdata    = '0;
        req_count    = 0;
        wb_count     = 0;
        last_wb_addr = '0;
        last_wb_data = '0;
        pending      = 1'b0;
        delay        = 0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = cache_cfg_pkg::word_t'(a) ^ 16'h5A5A;
        end
        forever begin
            @(negedge clk);
            if (!reset_n) begin
                mem_ack = 1'b0;
                pending = 1'b0;
            end else if (mem_ack) begin
                // four-phase, ack falls once req is gone
                if (!mem_req) begin
                    mem_ack = 1'b0;
                end
            end else if (pending || mem_req) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = $urandom_range(3, 0);
                end
                if (delay == 0) begin
                    for (int w = 0; w < 4; w++) begin
                        if (mem_write) begin
                            mem[{mem_addr, 2'(w)}] = mem_wdata[w*WB +: WB];
                        end else begin
                            mem_rdata[w*WB +: WB] = mem[{mem_addr, 2'(w)}];
                        end
                    end
                    if (mem_write) begin
                        wb_count++;
                        last_wb_addr = mem_addr;
                        last_wb_data = mem_wdata;
                    end
                    req_count++;
                    pending = 1'b0;
                    mem_ack = 1'b1;
                end else begin
                    delay--;
                end
            end
        end
    end

endmodule

// File: sim/tb_data_cache.sv
`timescale 1ns/1ns

module tb_data_cache;

    // 450 operations at about 25 cycles each, plus reset
    localparam int CYCLE_LIMIT = 20000;

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  cpu_req;
    logic                  cpu_write;
    cache_cfg_pkg::addr_t  cpu_addr;
    cache_cfg_pkg::word_t  cpu_wdata;
    logic                  cpu_ack;
    cache_cfg_pkg::word_t  cpu_rdata;
    logic                  mem_req;
    logic                  mem_write;
    cache_cfg_pkg::block_t mem_addr;
    cache_cfg_pkg::line_t  mem_wdata;
    logic                  mem_ack;
    cache_cfg_pkg::line_t  mem_rdata;
    int                    req_count;
    int                    wb_count;
    cache_cfg_pkg::block_t last_wb_addr;
    cache_cfg_pkg::line_t  last_wb_data;

    int                    cycle_count = 0;
    // memory contents as the cpu should see them, written words only
    cache_cfg_pkg::word_t  shadow [cache_cfg_pkg::addr_t];

    always #2 clk = ~clk;

    data_cache data_cache_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .cpu_req   (cpu_req),
        .cpu_write (cpu_write),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    main_memory_model memory (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_req      (mem_req),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .req_count    (req_count),
        .wb_count     (wb_count),
        .last_wb_addr (last_wb_addr),
        .last_wb_data (last_wb_data)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles without finishing", cycle_count);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // unwritten words keep the initial memory pattern
    function automatic cache_cfg_pkg::word_t expected_read(cache_cfg_pkg::addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ 16'h5A5A;
    endfunction

    function automatic cache_cfg_pkg::line_t expected_line(cache_cfg_pkg::block_t blk);
        cache_cfg_pkg::line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*16 +: 16] = expected_read({blk, 2'(w)});
        end
        return line;
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic cpu_access(input logic write, input cache_cfg_pkg::addr_t addr,
                              input cache_cfg_pkg::word_t wdata,
                              output cache_cfg_pkg::word_t rdata);
        @(negedge clk);
        cpu_req   = 1'b1;
        cpu_write = write;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        @(negedge clk);
        while (!cpu_ack) begin
            @(negedge clk);
        end
        rdata   = cpu_rdata;
        cpu_req = 1'b0;
        while (cpu_ack) begin
            @(negedge clk);
        end
        if (write) begin
            shadow[addr] = wdata;
        end
    endtask

    task automatic write_word(input cache_cfg_pkg::addr_t addr, input cache_cfg_pkg::word_t data);
        cache_cfg_pkg::word_t unused;
        cpu_access(1'b1, addr, data, unused);
    endtask

    task automatic read_check(input cache_cfg_pkg::addr_t addr, input string what);
        cache_cfg_pkg::word_t got;
        cpu_access(1'b0, addr, '0, got);
        check_equal(what, 64'(got), 64'(expected_read(addr)));
    endtask

    initial begin
        cache_cfg_pkg::addr_t line_a;
        cache_cfg_pkg::addr_t line_b;
        cache_cfg_pkg::addr_t line_c;
        cache_cfg_pkg::addr_t ra;
        cache_cfg_pkg::word_t wd;
        logic                 wr;
        int                   req_before;
        int                   wb_before;

        void'($urandom(67119));
        reset_n   = 1'b0;
        cpu_req   = 1'b0;
        cpu_write = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_equal("cpu_ack after reset", 64'(cpu_ack), 64'(0));
        check_equal("mem_req after reset", 64'(mem_req), 64'(0));
        check_equal("mem_write after reset", 64'(mem_write), 64'(0));

        // first read misses and fetches the line
        req_before = req_count;
        read_check(16'h0005, "first read");
        check_equal("fill on first read", 64'(req_count), 64'(req_before + 1));

        // write hit, then the rest of the line
        req_before = req_count;
        write_word(16'h0006, 16'hBEEF);
        check_equal("write hit memory traffic", 64'(req_count), 64'(req_before));
        read_check(16'h0006, "read after write hit");
        read_check(16'h0004, "line word 0");
        read_check(16'h0005, "line word 1");
        read_check(16'h0007, "line word 3");
        read_check(16'h0005, "repeated read");
        check_equal("hits stay off memory", 64'(req_count), 64'(req_before));

        // three dirty lines in set 0, the third evicts the first
        line_a = 16'h0100;
        line_b = 16'h0200;
        line_c = 16'h0300;
        write_word(line_a, 16'h1111);
        write_word(line_a + 16'd3, 16'h3333);
        write_word(line_b + 16'd1, 16'h2222);
        wb_before = wb_count;
        write_word(line_c + 16'd2, 16'h4444);
        check_equal("write-back count", 64'(wb_count), 64'(wb_before + 1));
        check_equal("write-back block", 64'(last_wb_addr), 64'(line_a[15:2]));
        check_equal("write-back data", last_wb_data, expected_line(line_a[15:2]));
        read_check(line_a, "evicted line word 0");
        read_check(line_a + 16'd3, "evicted line word 3");
        check_equal("second victim block", 64'(last_wb_addr), 64'(line_b[15:2]));

        // lru in set 1, touching A again makes B the victim
        line_a = 16'h1004;
        line_b = 16'h2004;
        line_c = 16'h3004;
        read_check(line_a, "lru fill A");
        read_check(line_b, "lru fill B");
        req_before = req_count;
        read_check(line_a + 16'd1, "lru hit A");
        check_equal("lru hit traffic", 64'(req_count), 64'(req_before));
        read_check(line_c, "lru fill C");
        req_before = req_count;
        read_check(line_a + 16'd2, "A kept after C");
        check_equal("A still cached", 64'(req_count), 64'(req_before));
        read_check(line_b + 16'd3, "B refetched");
        check_equal("B was evicted", 64'(req_count), 64'(req_before + 1));

        for (int i = 0; i < 400; i++) begin
            wr = 1'($urandom_range(1, 0));
            ra = cache_cfg_pkg::addr_t'($urandom_range(31, 0));
            wd = cache_cfg_pkg::word_t'($urandom());
            if (wr) begin
                write_word(ra, wd);
            end else begin
                read_check(ra, "random read");
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: source/array_port_if.sv
`timescale 1ns/1ns

interface array_port_if #(
    parameter type entry_t   = logic [15:0],
    parameter int  SET_COUNT = 2
);

    localparam int INDEX_BITS = $clog2(SET_COUNT);

    logic [INDEX_BITS-1:0] index;
    // one enable per way
    logic [1:0]            we;
    entry_t                wentry [2];
    // both ways of the indexed set
    entry_t                rentry [2];

    modport ctrl (
        output index,
        output we,
        output wentry,
        input  rentry
    );

    modport array (
        input  index,
        input  we,
        input  wentry,
        output rentry
    );

endinterface

// File: source/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // word and address width, addresses count words
    localparam int WORD_BITS   = 16;
    localparam int LINE_WORDS  = 4;
    localparam int OFFSET_BITS = 2;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [WORD_BITS-1:0] addr_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;

    // line address, i.e. word address without the block offset
    typedef logic [WORD_BITS-OFFSET_BITS-1:0] block_t;

    // full line address is kept so the tag does not depend on the set count
    typedef struct packed {
        logic   valid;
        logic   dirty;
        logic   recent;
        block_t block;
    } tag_entry_t;

    function automatic word_t line_word(line_t line, logic [OFFSET_BITS-1:0] offset);
        return line[offset*WORD_BITS +: WORD_BITS];
    endfunction

    // replace one word of a line, the rest is kept
    function automatic line_t merge_word(line_t line, word_t word,
                                         logic [OFFSET_BITS-1:0] offset);
        line_t merged;
        merged = line;
        merged[offset*WORD_BITS +: WORD_BITS] = word;
        return merged;
    endfunction

endpackage

// File: source/cache_controller.sv
`timescale 1ns/1ns

module cache_controller #(
    parameter int SET_COUNT = 2
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  cpu_req,
    input  logic                  cpu_write,
    input  cache_cfg_pkg::addr_t  cpu_addr,
    input  cache_cfg_pkg::word_t  cpu_wdata,
    output logic                  cpu_ack,
    output cache_cfg_pkg::word_t  cpu_rdata,
    output logic                  mem_req,
    output logic                  mem_write,
    output cache_cfg_pkg::block_t mem_addr,
    output cache_cfg_pkg::line_t  mem_wdata,
    input  logic                  mem_ack,
    input  cache_cfg_pkg::line_t  mem_rdata,
    array_port_if.ctrl            tags,
    array_port_if.ctrl            lines,
    lookup_if.ctrl                lk
);

    localparam int INDEX_BITS = $clog2(SET_COUNT);

    cache_ctrl_pkg::state_t                state;
    cache_ctrl_pkg::state_t                next_state;

    // latched cpu request
    cache_cfg_pkg::addr_t                  req_addr;
    logic                                  req_write;
    cache_cfg_pkg::word_t                  req_wdata;
    cache_cfg_pkg::block_t                 req_block;
    logic [cache_cfg_pkg::OFFSET_BITS-1:0] req_offset;
    logic [INDEX_BITS-1:0]                 set_index;

    logic                                  load_rdata;
    cache_cfg_pkg::word_t                  rdata_next;

    assign req_block  = req_addr[cache_cfg_pkg::WORD_BITS-1:cache_cfg_pkg::OFFSET_BITS];
    assign req_offset = req_addr[cache_cfg_pkg::OFFSET_BITS-1:0];
    assign set_index  = req_addr[cache_cfg_pkg::OFFSET_BITS +: INDEX_BITS];

    assign lk.addr     = req_addr;
    assign tags.index  = set_index;
    assign lines.index = set_index;

    always_comb begin
        next_state = state;
        load_rdata = 1'b0;
        rdata_next = lk.hit_word;
        tags.we    = '0;
        lines.we   = '0;
        // rewrite what is stored, recent cleared unless set below
        for (int w = 0; w < 2; w++) begin
            tags.wentry[w]        = tags.rentry[w];
            tags.wentry[w].recent = 1'b0;
            lines.wentry[w]       = lines.rentry[w];
        end

        case (state)
            cache_ctrl_pkg::IDLE: begin
                if (cpu_req) begin
                    next_state = cache_ctrl_pkg::LOOKUP;
                end
            end
            cache_ctrl_pkg::LOOKUP: begin
                if (lk.hit) begin
                    tags.we                        = 2'b11;
                    tags.wentry[lk.hit_way].recent = 1'b1;
                    if (req_write) begin
                        tags.wentry[lk.hit_way].dirty = 1'b1;
                        lines.we[lk.hit_way]          = 1'b1;
                        lines.wentry[lk.hit_way]      = cache_cfg_pkg::merge_word(
                            lines.rentry[lk.hit_way], req_wdata, req_offset);
                    end else begin
                        load_rdata = 1'b1;
                    end
                    next_state = cache_ctrl_pkg::RESPOND;
                end else if (lk.victim_dirty) begin
                    next_state = cache_ctrl_pkg::WB_REQ;
                end else begin
                    next_state = cache_ctrl_pkg::FILL_REQ;
                end
            end
            cache_ctrl_pkg::WB_REQ: begin
                if (mem_ack) begin
                    next_state = cache_ctrl_pkg::WB_DONE;
                end
            end
            cache_ctrl_pkg::WB_DONE: begin
                if (!mem_ack) begin
                    next_state = cache_ctrl_pkg::FILL_REQ;
                end
            end
            cache_ctrl_pkg::FILL_REQ: begin
                if (mem_ack) begin
                    // install the fetched line in the victim way
                    tags.we                    = 2'b11;
                    lines.we[lk.victim_way]    = 1'b1;
                    tags.wentry[lk.victim_way] = '{valid: 1'b1, dirty: req_write,
                                                   recent: 1'b1, block: req_block};
                    if (req_write) begin
                        lines.wentry[lk.victim_way] = cache_cfg_pkg::merge_word(
                            mem_rdata, req_wdata, req_offset);
                    end else begin
                        lines.wentry[lk.victim_way] = mem_rdata;
                    end
                    load_rdata = !req_write;
                    rdata_next = cache_cfg_pkg::line_word(mem_rdata, req_offset);
                    next_state = cache_ctrl_pkg::FILL_DONE;
                end
            end
            cache_ctrl_pkg::FILL_DONE: begin
                if (!mem_ack) begin
                    next_state = cache_ctrl_pkg::RESPOND;
                end
            end
            cache_ctrl_pkg::RESPOND: begin
                if (!cpu_req) begin
                    next_state = cache_ctrl_pkg::IDLE;
                end
            end
            default: begin
                next_state = cache_ctrl_pkg::IDLE;
            end
        endcase
    end

    // handshake outputs follow the state being entered
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= cache_ctrl_pkg::IDLE;
            cpu_ack   <= 1'b0;
            mem_req   <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state     <= next_state;
            cpu_ack   <= (next_state == cache_ctrl_pkg::RESPOND);
            mem_req   <= (next_state == cache_ctrl_pkg::WB_REQ) ||
                         (next_state == cache_ctrl_pkg::FILL_REQ);
            mem_write <= (next_state == cache_ctrl_pkg::WB_REQ);
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_ctrl_pkg::IDLE && cpu_req) begin
            req_addr  <= cpu_addr;
            req_write <= cpu_write;
            req_wdata <= cpu_wdata;
        end
        // victim line is only sent when a write-back follows
        if (state == cache_ctrl_pkg::LOOKUP) begin
            mem_wdata <= lines.rentry[lk.victim_way];
        end
        if (next_state == cache_ctrl_pkg::WB_REQ) begin
            mem_addr <= lk.victim_block;
        end else if (next_state == cache_ctrl_pkg::FILL_REQ) begin
            mem_addr <= req_block;
        end
        if (load_rdata) begin
            cpu_rdata <= rdata_next;
        end
    end

    // the cpu is never answered while memory is still busy
    assert property (@(posedge clk) disable iff (!reset_n) !(cpu_ack && mem_req))
    else $error("cpu_ack and mem_req high together");

    assert property (@(posedge clk) disable iff (!reset_n) mem_write |-> mem_req)
    else $error("mem_write without mem_req");

endmodule

// File: source/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // blocking controller, one request in flight
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_DONE,
        FILL_REQ,
        FILL_DONE,
        RESPOND
    } state_t;

    // way 0 or way 1
    typedef logic [0:0] way_t;

endpackage

// File: source/data_cache.sv
`timescale 1ns/1ns

module data_cache (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  cpu_req,
    input  logic                  cpu_write,
    input  cache_cfg_pkg::addr_t  cpu_addr,
    input  cache_cfg_pkg::word_t  cpu_wdata,
    output logic                  cpu_ack,
    output cache_cfg_pkg::word_t  cpu_rdata,
    output logic                  mem_req,
    output logic                  mem_write,
    output cache_cfg_pkg::block_t mem_addr,
    output cache_cfg_pkg::line_t  mem_wdata,
    input  logic                  mem_ack,
    input  cache_cfg_pkg::line_t  mem_rdata
);

    // number of sets, power of two
    localparam int SET_COUNT = 2;

    array_port_if #(
        .entry_t   (cache_cfg_pkg::tag_entry_t),
        .SET_COUNT (SET_COUNT)
    ) tag_port ();

    array_port_if #(
        .entry_t   (cache_cfg_pkg::line_t),
        .SET_COUNT (SET_COUNT)
    ) line_port ();

    lookup_if lk_bus ();

    way_array #(
        .entry_t   (cache_cfg_pkg::tag_entry_t),
        .SET_COUNT (SET_COUNT)
    ) tag_store (
        .clk     (clk),
        .reset_n (reset_n),
        .port    (tag_port.array)
    );

    way_array #(
        .entry_t   (cache_cfg_pkg::line_t),
        .SET_COUNT (SET_COUNT)
    ) line_store (
        .clk     (clk),
        .reset_n (reset_n),
        .port    (line_port.array)
    );

    // lookup reads the same array ports the controller writes
    tag_compare #(
        .SET_COUNT (SET_COUNT)
    ) tag_compare_inst (
        .tags  (tag_port.ctrl),
        .lines (line_port.ctrl),
        .lk    (lk_bus.cmp)
    );

    cache_controller #(
        .SET_COUNT (SET_COUNT)
    ) controller_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .cpu_req   (cpu_req),
        .cpu_write (cpu_write),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .tags      (tag_port.ctrl),
        .lines     (line_port.ctrl),
        .lk        (lk_bus.ctrl)
    );

endmodule

// File: source/lookup_if.sv
`timescale 1ns/1ns

interface lookup_if;

    // latched request address from the controller
    cache_cfg_pkg::addr_t  addr;

    logic                  hit;
    cache_ctrl_pkg::way_t  hit_way;
    cache_ctrl_pkg::way_t  victim_way;
    // victim is valid and dirty, needs a write-back
    logic                  victim_dirty;
    cache_cfg_pkg::block_t victim_block;
    cache_cfg_pkg::word_t  hit_word;

    modport cmp (
        input  addr,
        output hit,
        output hit_way,
        output victim_way,
        output victim_dirty,
        output victim_block,
        output hit_word
    );

    modport ctrl (
        output addr,
        input  hit,
        input  hit_way,
        input  victim_way,
        input  victim_dirty,
        input  victim_block,
        input  hit_word
    );

endinterface

// File: source/tag_compare.sv
`timescale 1ns/1ns

module tag_compare #(
    parameter int SET_COUNT = 2
) (
    array_port_if.ctrl tags,
    array_port_if.ctrl lines,
    lookup_if.cmp      lk
);

    localparam int INDEX_BITS = $clog2(SET_COUNT);

    cache_cfg_pkg::block_t                         req_block;
    logic [cache_cfg_pkg::OFFSET_BITS-1:0]         req_offset;
    logic [1:0]                                    way_hit;
    cache_ctrl_pkg::way_t                          hit_sel;
    cache_ctrl_pkg::way_t                          victim_sel;
    cache_cfg_pkg::tag_entry_t                     victim;

    assign req_block  = lk.addr[cache_cfg_pkg::WORD_BITS-1:cache_cfg_pkg::OFFSET_BITS];
    assign req_offset = lk.addr[cache_cfg_pkg::OFFSET_BITS-1:0];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = tags.rentry[w].valid && (tags.rentry[w].block == req_block);
        end
        hit_sel = way_hit[1] ? 1'b1 : 1'b0;

        // way 0 goes first unless it was the last one used
        victim_sel = tags.rentry[0].recent ? 1'b1 : 1'b0;
        victim     = tags.rentry[victim_sel];

        lk.hit          = |way_hit;
        lk.hit_way      = hit_sel;
        lk.victim_way   = victim_sel;
        lk.victim_dirty = victim.valid && victim.dirty;
        lk.victim_block = victim.block;
        lk.hit_word     = cache_cfg_pkg::line_word(lines.rentry[hit_sel], req_offset);

        // a block is installed in one way only
        if (!$isunknown(way_hit)) begin
            assert (!(way_hit[0] && way_hit[1]))
            else $error("block %h hits in both ways", req_block);
        end
        // the stored line of a valid victim belongs to the set being looked up
        if (!$isunknown(victim) && victim.valid) begin
            assert (victim.block[INDEX_BITS-1:0] == req_block[INDEX_BITS-1:0])
            else $error("victim block %h outside set of %h", victim.block, req_block);
        end
    end

endmodule

// File: source/way_array.sv
`timescale 1ns/1ns

module way_array #(
    parameter type entry_t   = logic [15:0],
    parameter int  SET_COUNT = 2
) (
    input logic         clk,
    input logic         reset_n,
    array_port_if.array port
);

    localparam int INDEX_BITS = $clog2(SET_COUNT);

    entry_t                store [2][SET_COUNT];
    logic [INDEX_BITS-1:0] set_sel;

    assign set_sel = port.index;

    // combinational read of both ways
    assign port.rentry[0] = store[0][set_sel];
    assign port.rentry[1] = store[1][set_sel];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            // cleared entries read as invalid tags
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < SET_COUNT; s++) begin
                    store[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (port.we[w]) begin
                    store[w][set_sel] <= port.wentry[w];
                end
            end
        end
    end

    // a write must land on a known set
    assert property (@(posedge clk) disable iff (!reset_n)
        (|port.we) |-> !$isunknown(port.index))
    else $error("way_array write with unknown index");

endmodule
